// File: compile.f
+incdir+include
source/lsu_pkg.sv
source/lsu_decode.sv
source/lsu_bus_master.sv
source/clint_timer.sv
source/lsu_load_align.sv
source/lsu_top.sv
tb/lsu_asserts.sv
tb/tb_lsu.sv

// File: run.sh
#!/bin/sh
# build and run the LSU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_lsu \
    -o sim_lsu --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_lsu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0

// File: tb/tb_lsu.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module tb_lsu;

    import lsu_pkg::*;

    localparam int N_REQ = 300;
    localparam int TIMEOUT_CYCLES = N_REQ * `LSU_TIMEOUT_MARGIN + `LSU_RESET_CYCLES;
    localparam logic [31:0] MEM_BASE = 32'h0000_1000;
    localparam logic [31:0] ERR_BASE = 32'h0000_2000;
    // edges from the acceptance edge to done
    localparam int LOCAL_LATENCY = 2;
    localparam int TIMER_LATENCY = 3;

    logic        clk = 1'b0;
    logic        rst;
    logic        ready;
    logic        ren;
    logic        wen;
    lsu_width_e  width;
    logic        sign;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        done;
    logic [31:0] rdata;
    logic        access_error;

    logic        awvalid;
    logic [31:0] awaddr;
    logic [2:0]  awsize;
    logic        awready = 1'b0;
    logic        wvalid;
    logic [31:0] wdata_axi;
    logic [3:0]  wstrb;
    logic        wlast;
    logic        wready = 1'b0;
    logic        bready;
    logic        bvalid = 1'b0;
    logic [1:0]  bresp = `LSU_RESP_OKAY;
    logic        arvalid;
    logic [31:0] araddr;
    logic [2:0]  arsize;
    logic        arready = 1'b0;
    logic        rready;
    logic        rvalid = 1'b0;
    logic [1:0]  rresp = `LSU_RESP_OKAY;
    logic [31:0] rdata_axi = 32'h0;

    // slave memory and the reference copy of it
    logic [7:0]  mem [0:255];
    logic [7:0]  ref_mem [0:255];

    int          cycle = 0;
    int          errors = 0;
    int          done_count = 0;
    int          issue_cycle = 0;
    int          exp_latency = 0;
    logic [31:0] exp_rdata = 32'h0;
    logic [3:0]  exp_strb = 4'h0;
    logic [2:0]  exp_size = 3'h0;
    logic [31:0] exp_wdata = 32'h0;
    logic        exp_error = 1'b0;
    logic        check_rdata = 1'b0;
    logic        is_timer_load = 1'b0;
    logic        is_local = 1'b0;
    logic        is_mem_store = 1'b0;
    logic [7:0]  store_base = 8'h0;
    logic [31:0] last_timer = 32'h0;

    int unsigned ar_stall = 0;
    int unsigned r_stall = 0;
    int unsigned aw_stall = 0;
    int unsigned w_stall = 0;
    int unsigned b_stall = 0;
    logic        r_pending = 1'b0;
    logic        b_pending = 1'b0;
    logic [31:0] ar_addr = 32'h0;
    logic [31:0] aw_addr = 32'h0;

    lsu_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .ready        (ready),
        .ren          (ren),
        .wen          (wen),
        .width        (width),
        .sign         (sign),
        .addr         (addr),
        .wdata        (wdata),
        .done         (done),
        .rdata        (rdata),
        .access_error (access_error),
        .awvalid      (awvalid),
        .awaddr       (awaddr),
        .awsize       (awsize),
        .awready      (awready),
        .wvalid       (wvalid),
        .wdata_axi    (wdata_axi),
        .wstrb        (wstrb),
        .wlast        (wlast),
        .wready       (wready),
        .bready       (bready),
        .bvalid       (bvalid),
        .bresp        (bresp),
        .arvalid      (arvalid),
        .araddr       (araddr),
        .arsize       (arsize),
        .arready      (arready),
        .rready       (rready),
        .rvalid       (rvalid),
        .rresp        (rresp),
        .rdata_axi    (rdata_axi)
    );

    always #10 clk = ~clk;

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
        errors++;
    endtask

    task automatic report_failure(string msg);
        $display("Error at %0t: %s", $time, msg);
        errors++;
    endtask

    function automatic logic in_window(logic [31:0] a, logic [31:0] base, int unsigned size);
        return (a >= base) && (a < base + size);
    endfunction

    // byte lanes touched by an access of width w at byte offset off
    function automatic logic [3:0] expected_strobe(logic [1:0] off, lsu_width_e w);
        case (w)
            width_byte: return 4'b0001 << off;
            width_half: return 4'b0011 << off;
            width_word: return 4'b1111;
            default:    return 4'b0000;
        endcase
    endfunction

    // load value built byte by byte from the reference memory
    function automatic logic [31:0] expected_load(logic [7:0] off, lsu_width_e w, logic s);
        logic [7:0] b0;
        logic [7:0] b1;
        b0 = ref_mem[off];
        b1 = ref_mem[off + 8'd1];
        case (w)
            width_byte: return s ? {{24{b0[7]}}, b0} : {24'h0, b0};
            width_half: return s ? {{16{b1[7]}}, b1, b0} : {16'h0, b1, b0};
            width_word: return {ref_mem[off + 8'd3], ref_mem[off + 8'd2], b1, b0};
            default:    return 32'h0;
        endcase
    endfunction

    task automatic apply_store(logic [7:0] off, logic [3:0] strb, logic [31:0] data);
        logic [7:0] base;
        base = off & 8'hfc;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                ref_mem[base + 8'(i)] = data[8*i +: 8];
            end
        end
    endtask

    function automatic logic [31:0] mem_word(logic [5:0] w);
        return {mem[{w, 2'd3}], mem[{w, 2'd2}], mem[{w, 2'd1}], mem[{w, 2'd0}]};
    endfunction

    // AXI4-Lite memory slave with 0 to 3 stall cycles on every ready and response
    always @(negedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            if (arready) begin
                arready   <= 1'b0;
                ar_stall  <= $urandom % 4;
                r_pending <= 1'b1;
                r_stall   <= $urandom % 4;
            end else if (arvalid) begin
                if (ar_stall == 0) begin
                    assert (araddr == addr) else report_mismatch("araddr", araddr, addr);
                    assert (arsize == exp_size)
                        else report_mismatch("arsize", 32'(arsize), 32'(exp_size));
                    arready <= 1'b1;
                    ar_addr <= araddr;
                end else begin
                    ar_stall <= ar_stall - 1;
                end
            end
            if (rvalid) begin
                rvalid <= 1'b0;
            end else if (r_pending) begin
                if (r_stall == 0) begin
                    assert (rready)
                        else report_failure("rready low while the read response was offered");
                    rvalid    <= 1'b1;
                    r_pending <= 1'b0;
                    if (in_window(ar_addr, ERR_BASE, 16)) begin
                        rresp     <= `LSU_RESP_SLVERR;
                        rdata_axi <= 32'h0;
                    end else begin
                        rresp     <= `LSU_RESP_OKAY;
                        rdata_axi <= mem_word(ar_addr[7:2]);
                    end
                end else begin
                    r_stall <= r_stall - 1;
                end
            end
            if (awready) begin
                awready  <= 1'b0;
                aw_stall <= $urandom % 4;
            end else if (awvalid) begin
                if (aw_stall == 0) begin
                    assert (awaddr == addr) else report_mismatch("awaddr", awaddr, addr);
                    assert (awsize == exp_size)
                        else report_mismatch("awsize", 32'(awsize), 32'(exp_size));
                    awready <= 1'b1;
                    aw_addr <= awaddr;
                end else begin
                    aw_stall <= aw_stall - 1;
                end
            end
            if (wready) begin
                wready    <= 1'b0;
                w_stall   <= $urandom % 4;
                b_pending <= 1'b1;
                b_stall   <= $urandom % 4;
            end else if (wvalid) begin
                if (w_stall == 0) begin
                    assert (wstrb == exp_strb)
                        else report_mismatch("wstrb", 32'(wstrb), 32'(exp_strb));
                    assert (wdata_axi == exp_wdata)
                        else report_mismatch("wdata", wdata_axi, exp_wdata);
                    assert (wlast) else report_failure("wlast low on a single-beat write");
                    wready <= 1'b1;
                    // error window holds no storage
                    if (!in_window(aw_addr, ERR_BASE, 16)) begin
                        for (int i = 0; i < 4; i++) begin
                            if (wstrb[i]) begin
                                mem[{aw_addr[7:2], 2'(i)}] = wdata_axi[8*i +: 8];
                            end
                        end
                    end
                end else begin
                    w_stall <= w_stall - 1;
                end
            end
            if (bvalid) begin
                bvalid <= 1'b0;
            end else if (b_pending) begin
                if (b_stall == 0) begin
                    assert (bready)
                        else report_failure("bready low while the write response was offered");
                    bvalid    <= 1'b1;
                    b_pending <= 1'b0;
                    bresp     <= in_window(aw_addr, ERR_BASE, 16) ? `LSU_RESP_SLVERR
                                                                  : `LSU_RESP_OKAY;
                end else begin
                    b_stall <= b_stall - 1;
                end
            end
        end
    end

    // compare on every done
    always @(negedge clk) begin
        if (!rst && done) begin
            done_count++;
            assert (access_error == exp_error)
                else report_mismatch("access_error", 32'(access_error), 32'(exp_error));
            if (check_rdata) begin
                assert (rdata == exp_rdata) else report_mismatch("rdata", rdata, exp_rdata);
            end
            if (exp_latency > 0) begin
                assert (cycle - issue_cycle - 1 == exp_latency)
                    else report_mismatch("done latency", 32'(cycle - issue_cycle - 1),
                                         32'(exp_latency));
            end
            if (is_timer_load) begin
                // mtime counts edges after reset release
                assert (rdata >= 32'(issue_cycle - `LSU_RESET_CYCLES) &&
                        rdata <= 32'(cycle - `LSU_RESET_CYCLES))
                    else report_failure("timer value outside the cycle window of the request");
                assert (rdata > last_timer)
                    else report_failure("timer value did not increase since the last read");
                last_timer = rdata;
            end
            if (is_mem_store) begin
                for (int i = 0; i < 4; i++) begin
                    assert (mem[store_base + 8'(i)] == ref_mem[store_base + 8'(i)])
                        else report_mismatch($sformatf("mem[%0d]", store_base + 8'(i)),
                                             32'(mem[store_base + 8'(i)]),
                                             32'(ref_mem[store_base + 8'(i)]));
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d requests done",
                     cycle, done_count, N_REQ);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        int unsigned kind;
        int unsigned gap;
        logic        load;
        logic        misaligned;
        logic        timer;
        logic        errwin;
        void'($urandom(90));
        rst   = 1'b1;
        ready = 1'b0;
        ren   = 1'b0;
        wen   = 1'b0;
        width = width_none;
        sign  = 1'b0;
        addr  = 32'h0;
        wdata = 32'h0;
        for (int i = 0; i < 256; i++) begin
            mem[i]     = 8'(i * 29 + 7);
            ref_mem[i] = 8'(i * 29 + 7);
        end
        repeat (`LSU_RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int n = 0; n < N_REQ; n++) begin
            kind  = $urandom % 8;
            sign  = 1'($urandom % 2);
            wdata = $urandom;
            load  = 1'($urandom % 2);
            case ($urandom % 3)
                0:       width = width_byte;
                1:       width = width_half;
                default: width = width_word;
            endcase
            if (kind < 6) begin
                addr = (kind < 5) ? MEM_BASE + ($urandom % 256) : ERR_BASE + ($urandom % 16);
                // most accesses aligned and the rest as they fall
                if ($urandom % 4 != 0) begin
                    if (width == width_half) addr[0] = 1'b0;
                    if (width == width_word) addr[1:0] = 2'b00;
                end
            end else if ($urandom % 4 == 0) begin
                addr = `LSU_CLINT_BASE + ($urandom % 8);
                load = 1'b0;
            end else begin
                addr  = `LSU_CLINT_BASE;
                width = width_word;
                load  = 1'b1;
            end

            misaligned = (width == width_half && addr[0]) ||
                         (width == width_word && addr[1:0] != 2'b00);
            timer      = in_window(addr, `LSU_CLINT_BASE, 8);
            errwin     = in_window(addr, ERR_BASE, 16);
            exp_error  = misaligned || errwin || (timer && !load);
            exp_strb   = expected_strobe(addr[1:0], width);
            // AXI size is log2 of the bytes in the access
            case (width)
                width_byte: exp_size = 3'd0;
                width_half: exp_size = 3'd1;
                default:    exp_size = 3'd2;
            endcase
            exp_wdata  = wdata << (8 * int'(addr[1:0]));
            is_local   = misaligned || timer;
            is_timer_load = timer && load;
            exp_latency = (misaligned || (timer && !load)) ? LOCAL_LATENCY :
                          (is_timer_load ? TIMER_LATENCY : 0);
            is_mem_store = !load && !exp_error && in_window(addr, MEM_BASE, 256);
            store_base   = addr[7:0] & 8'hfc;
            // stores always return zero
            check_rdata  = !load || (!exp_error && !timer);
            exp_rdata    = load ? expected_load(addr[7:0], width, sign) : 32'h0;
            if (is_mem_store) begin
                apply_store(addr[7:0], exp_strb, exp_wdata);
            end

            ren = load;
            wen = !load;
            gap = $urandom % 2;
            repeat (gap) @(negedge clk);
            ready       = 1'b1;
            issue_cycle = cycle;
            @(negedge clk);
            while (!done) begin
                if (is_local) begin
                    assert (!arvalid && !awvalid && !wvalid)
                        else report_failure("AXI valid raised during a local access");
                end
                @(negedge clk);
            end
            ren   = 1'b0;
            wen   = 1'b0;
            ready = 1'b0;
            @(negedge clk);
        end

        repeat (4) @(negedge clk);
        assert (done_count == N_REQ)
            else report_mismatch("done count", 32'(done_count), 32'(N_REQ));
        for (int i = 0; i < 256; i++) begin
            assert (mem[i] == ref_mem[i])
                else report_mismatch($sformatf("mem[%0d]", i), 32'(mem[i]), 32'(ref_mem[i]));
        end
        $display("requests checked: %0d, errors: %0d", done_count, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/lsu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_asserts (
    input logic                clk,
    input logic                rst,
    input lsu_pkg::bus_state_e state,
    input logic                arvalid,
    input logic                arready,
    input logic                awvalid,
    input logic                awready,
    input logic                wvalid,
    input logic                wready,
    input logic                raw_valid
);

    import lsu_pkg::*;

    logic aw_seen;

    // set by the AW handshake, cleared by the W handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            aw_seen <= 1'b0;
        end else if (awvalid && awready) begin
            aw_seen <= 1'b1;
        end else if (wvalid && wready) begin
            aw_seen <= 1'b0;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        (arvalid && !arready) |=> arvalid)
        else $error("arvalid dropped before its handshake");

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        (awvalid && !awready) |=> awvalid)
        else $error("awvalid dropped before its handshake");

    w_hold: assert property (@(posedge clk) disable iff (rst)
        (wvalid && !wready) |=> wvalid)
        else $error("wvalid dropped before its handshake");

    w_after_aw: assert property (@(posedge clk) disable iff (rst)
        wvalid |-> aw_seen)
        else $error("wvalid raised before the AW handshake");

    // the request is still held while its done is on the way out
    single_accept: assert property (@(posedge clk) disable iff (rst)
        raw_valid |=> (state == bus_idle))
        else $error("request accepted again before its done");

endmodule

bind lsu_bus_master lsu_asserts i_asserts (
    .clk       (clk),
    .rst       (rst),
    .state     (state),
    .arvalid   (arvalid),
    .arready   (arready),
    .awvalid   (awvalid),
    .awready   (awready),
    .wvalid    (wvalid),
    .wready    (wready),
    .raw_valid (raw_valid)
);

`default_nettype wire

// File: source/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                ready,
    input  logic                ren,
    input  logic                wen,
    input  lsu_pkg::lsu_width_e width,
    input  logic                sign,
    input  logic [31:0]         addr,
    input  logic [31:0]         wdata,
    output logic                done,
    output logic [31:0]         rdata,
    output logic                access_error,
    output logic                awvalid,
    output logic [31:0]         awaddr,
    output logic [2:0]          awsize,
    input  logic                awready,
    output logic                wvalid,
    output logic [31:0]         wdata_axi,
    output logic [3:0]          wstrb,
    output logic                wlast,
    input  logic                wready,
    output logic                bready,
    input  logic                bvalid,
    input  logic [1:0]          bresp,
    output logic                arvalid,
    output logic [31:0]         araddr,
    output logic [2:0]          arsize,
    input  logic                arready,
    output logic                rready,
    input  logic                rvalid,
    input  logic [1:0]          rresp,
    input  logic [31:0]         rdata_axi
);

    import lsu_pkg::*;

    lsu_access_t access;
    logic        raw_valid;
    logic [31:0] raw_word;
    logic        raw_error;
    logic        clint_arvalid;
    logic [2:0]  clint_araddr;
    logic        clint_arready;
    logic        clint_rvalid;
    logic [1:0]  clint_rresp;
    logic [31:0] clint_rdata;

    lsu_decode i_decode (
        .width  (width),
        .sign   (sign),
        .addr   (addr),
        .wdata  (wdata),
        .access (access)
    );

    lsu_bus_master i_bus_master (
        .clk           (clk),
        .rst           (rst),
        .ready         (ready),
        .ren           (ren),
        .wen           (wen),
        .addr          (addr),
        .access        (access),
        .awvalid       (awvalid),
        .awaddr        (awaddr),
        .awsize        (awsize),
        .awready       (awready),
        .wvalid        (wvalid),
        .wdata         (wdata_axi),
        .wstrb         (wstrb),
        .wlast         (wlast),
        .wready        (wready),
        .bready        (bready),
        .bvalid        (bvalid),
        .bresp         (bresp),
        .arvalid       (arvalid),
        .araddr        (araddr),
        .arsize        (arsize),
        .arready       (arready),
        .rready        (rready),
        .rvalid        (rvalid),
        .rresp         (rresp),
        .rdata         (rdata_axi),
        .clint_arvalid (clint_arvalid),
        .clint_araddr  (clint_araddr),
        .clint_arready (clint_arready),
        .clint_rvalid  (clint_rvalid),
        .clint_rresp   (clint_rresp),
        .clint_rdata   (clint_rdata),
        .raw_valid     (raw_valid),
        .raw_word      (raw_word),
        .raw_error     (raw_error)
    );

    // master always accepts timer read data
    clint_timer i_clint_timer (
        .clk     (clk),
        .rst     (rst),
        .arvalid (clint_arvalid),
        .araddr  (clint_araddr),
        .rready  (1'b1),
        .arready (clint_arready),
        .rvalid  (clint_rvalid),
        .rdata   (clint_rdata),
        .rresp   (clint_rresp)
    );

    lsu_load_align i_load_align (
        .clk          (clk),
        .rst          (rst),
        .raw_valid    (raw_valid),
        .raw_word     (raw_word),
        .raw_error    (raw_error),
        .access       (access),
        .done         (done),
        .rdata        (rdata),
        .access_error (access_error)
    );

endmodule

`default_nettype wire

// File: source/lsu_load_align.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 raw_valid,
    input  logic [31:0]          raw_word,
    input  logic                 raw_error,
    input  lsu_pkg::lsu_access_t access,
    output logic                 done,
    output logic [31:0]          rdata,
    output logic                 access_error
);

    import lsu_pkg::*;

    logic [31:0] shifted;
    logic [31:0] extended;

    // bring the addressed byte down to lane 0
    assign shifted = raw_word >> {access.byte_off, 3'b000};

    always_comb begin
        case (access.width)
            width_byte: extended = {{24{shifted[7] & access.sign}}, shifted[7:0]};
            width_half: extended = {{16{shifted[15] & access.sign}}, shifted[15:0]};
            width_word: extended = shifted;
            default:    extended = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done         <= 1'b0;
            access_error <= 1'b0;
        end else begin
            done         <= raw_valid;
            access_error <= raw_valid && raw_error;
        end
    end

    always_ff @(posedge clk) begin
        if (raw_valid) begin
            rdata <= extended;
        end
    end

endmodule

`default_nettype wire

// File: source/clint_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module clint_timer (
    input  logic        clk,
    input  logic        rst,
    input  logic        arvalid,
    input  logic [2:0]  araddr,
    input  logic        rready,
    output logic        arready,
    output logic        rvalid,
    output logic [31:0] rdata,
    output logic [1:0]  rresp
);

    logic [63:0] mtime;

    // address is always taken at once
    assign arready = 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    // read data stays up until the master takes it
    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (arvalid && arready) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // offset bit 2 picks the upper half
    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rdata <= araddr[2] ? mtime[63:32] : mtime[31:0];
            rresp <= (araddr[1:0] != 2'b00) ? `LSU_RESP_SLVERR : `LSU_RESP_OKAY;
        end
    end

endmodule

`default_nettype wire

// File: source/lsu_bus_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_bus_master (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ready,
    input  logic                 ren,
    input  logic                 wen,
    input  logic [31:0]          addr,
    input  lsu_pkg::lsu_access_t access,
    output logic                 awvalid,
    output logic [31:0]          awaddr,
    output logic [2:0]           awsize,
    input  logic                 awready,
    output logic                 wvalid,
    output logic [31:0]          wdata,
    output logic [3:0]           wstrb,
    output logic                 wlast,
    input  logic                 wready,
    output logic                 bready,
    input  logic                 bvalid,
    input  logic [1:0]           bresp,
    output logic                 arvalid,
    output logic [31:0]          araddr,
    output logic [2:0]           arsize,
    input  logic                 arready,
    output logic                 rready,
    input  logic                 rvalid,
    input  logic [1:0]           rresp,
    input  logic [31:0]          rdata,
    output logic                 clint_arvalid,
    output logic [2:0]           clint_araddr,
    input  logic                 clint_arready,
    input  logic                 clint_rvalid,
    input  logic [1:0]           clint_rresp,
    input  logic [31:0]          clint_rdata,
    output logic                 raw_valid,
    output logic [31:0]          raw_word,
    output logic                 raw_error
);

    import lsu_pkg::*;

    bus_state_e  state;
    logic        accept;
    logic        local_fail;
    logic        ar_ready_sel;
    logic        r_valid_sel;
    logic [1:0]  r_resp_sel;
    logic [31:0] r_data_sel;

    // raw_valid blocks the held request from being taken twice
    assign accept = (state == bus_idle) && ready && (ren || wen) && !raw_valid;

    // misaligned accesses and timer stores never reach a bus
    assign local_fail = access.misaligned || (access.to_clint && !ren);

    assign ar_ready_sel = access.to_clint ? clint_arready : arready;
    assign r_valid_sel  = access.to_clint ? clint_rvalid : rvalid;
    assign r_resp_sel   = access.to_clint ? clint_rresp : rresp;
    assign r_data_sel   = access.to_clint ? clint_rdata : rdata;

    assign arvalid       = (state == bus_addr_read) && !access.to_clint;
    assign araddr        = addr;
    assign arsize        = access.size;
    assign rready        = (state == bus_wait_read) && !access.to_clint;
    assign clint_arvalid = (state == bus_addr_read) && access.to_clint;
    assign clint_araddr  = addr[2:0];

    assign awvalid = (state == bus_addr_write);
    assign awaddr  = addr;
    assign awsize  = access.size;
    assign wvalid  = (state == bus_data_write);
    assign wdata   = access.wdata_shifted;
    assign wstrb   = access.strb;
    assign wlast   = wvalid;
    assign bready  = (state == bus_wait_resp) && !local_fail;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= bus_idle;
            raw_valid <= 1'b0;
            raw_error <= 1'b0;
        end else begin
            raw_valid <= 1'b0;
            case (state)
                bus_idle: begin
                    if (accept) begin
                        if (local_fail) begin
                            state <= bus_wait_resp;
                        end else if (ren) begin
                            state <= bus_addr_read;
                        end else begin
                            state <= bus_addr_write;
                        end
                    end
                end
                bus_addr_read: begin
                    if (ar_ready_sel) begin
                        state <= bus_wait_read;
                    end
                end
                bus_wait_read: begin
                    if (r_valid_sel) begin
                        raw_valid <= 1'b1;
                        raw_error <= (r_resp_sel != `LSU_RESP_OKAY);
                        state     <= bus_idle;
                    end
                end
                bus_addr_write: begin
                    if (awready) begin
                        state <= bus_data_write;
                    end
                end
                bus_data_write: begin
                    if (wready) begin
                        state <= bus_wait_resp;
                    end
                end
                bus_wait_resp: begin
                    // locally failed accesses spend one cycle here
                    if (local_fail) begin
                        raw_valid <= 1'b1;
                        raw_error <= 1'b1;
                        state     <= bus_idle;
                    end else if (bvalid) begin
                        raw_valid <= 1'b1;
                        raw_error <= (bresp != `LSU_RESP_OKAY);
                        state     <= bus_idle;
                    end
                end
                default: state <= bus_idle;
            endcase
        end
    end

    // stores and failed accesses return a zero word
    always_ff @(posedge clk) begin
        if (state == bus_wait_read && r_valid_sel) begin
            raw_word <= r_data_sel;
        end else if (state == bus_wait_resp) begin
            raw_word <= '0;
        end
    end

endmodule

`default_nettype wire

// File: source/lsu_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_decode (
    input  lsu_pkg::lsu_width_e  width,
    input  logic                 sign,
    input  logic [31:0]          addr,
    input  logic [31:0]          wdata,
    output lsu_pkg::lsu_access_t access
);

    import lsu_pkg::*;

    always_comb begin
        access          = '0;
        access.byte_off = addr[1:0];
        access.width    = width;
        access.sign     = sign;

        // store data moves up into the addressed byte lane
        access.wdata_shifted = wdata << {addr[1:0], 3'b000};

        access.to_clint = (addr >= `LSU_CLINT_BASE) && (addr <= `LSU_CLINT_END);

        case (width)
            width_byte: begin
                access.strb       = 4'b0001 << addr[1:0];
                access.size       = 3'b000;
                access.misaligned = 1'b0;
            end
            width_half: begin
                access.strb       = addr[1] ? 4'b1100 : 4'b0011;
                access.size       = 3'b001;
                access.misaligned = addr[0];
            end
            width_word: begin
                access.strb       = 4'b1111;
                access.size       = 3'b010;
                access.misaligned = |addr[1:0];
            end
            default: begin
                // no bytes touched
                access.strb       = 4'b0000;
                access.size       = 3'b000;
                access.misaligned = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // access width, same encoding as the core's mask field
    typedef enum logic [1:0] {
        width_none = 2'b00,
        width_byte = 2'b01,
        width_half = 2'b10,
        width_word = 2'b11
    } lsu_width_e;

    typedef enum logic [2:0] {
        bus_idle       = 3'd0,
        bus_addr_read  = 3'd1,
        bus_wait_read  = 3'd2,
        bus_addr_write = 3'd3,
        bus_data_write = 3'd4,
        bus_wait_resp  = 3'd5
    } bus_state_e;

    // decoded request, shared by bus master and load align
    typedef struct packed {
        logic [3:0]  strb;
        logic [2:0]  size;
        logic [31:0] wdata_shifted;
        logic        to_clint;
        logic        misaligned;
        logic [1:0]  byte_off;
        lsu_width_e  width;
        logic        sign;
    } lsu_access_t;

endpackage

`default_nettype wire

// File: include/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// inclusive address window of the core-local timer
// low half of mtime sits at the base, high half four bytes above
`define LSU_CLINT_BASE 32'ha000_0048
`define LSU_CLINT_END  32'ha000_004f

// AXI response codes
`define LSU_RESP_OKAY   2'b00
`define LSU_RESP_SLVERR 2'b10

// cycles allowed per request before the run is abandoned
`define LSU_TIMEOUT_MARGIN 20

// reset length in clock cycles
`define LSU_RESET_CYCLES 16

`endif
